// ==== soc_ctl_pkg.sv ====
// Bus widths, CSR bank and register indices, interrupt bit positions and shared types
package soc_ctl_pkg;

	// ------------------------------
	// Widths
	// ------------------------------
	localparam int WB_ADR_W   = 32;
	localparam int CSR_DATA_W = 32;
	localparam int CSR_ADDR_W = 14;
	localparam int CSR_BANK_W = 4;
	localparam int CSR_REG_W  = 10;
	localparam int IRQ_W      = 32;

	typedef logic [WB_ADR_W-1:0]   wb_adr_t;
	typedef logic [CSR_DATA_W-1:0] csr_data_t;
	// Bank in the upper bits, register index below
	typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
	typedef logic [CSR_BANK_W-1:0] csr_bank_t;
	typedef logic [CSR_REG_W-1:0]  csr_reg_t;
	typedef logic [IRQ_W-1:0]      irq_vec_t;

	// ------------------------------
	// Bank numbers
	// ------------------------------
	localparam csr_bank_t CSR_BANK_UART   = 4'd0;
	localparam csr_bank_t CSR_BANK_SYSCTL = 4'd1;

	// System controller registers
	localparam csr_reg_t REG_GPIO_IN       = 10'd0;
	localparam csr_reg_t REG_GPIO_OUT      = 10'd1;
	localparam csr_reg_t REG_GPIO_IRQ_EN   = 10'd2;
	localparam csr_reg_t REG_TIMER_CTRL    = 10'd3;
	localparam csr_reg_t REG_TIMER_COMPARE = 10'd4;
	localparam csr_reg_t REG_TIMER_COUNTER = 10'd5;
	localparam csr_reg_t REG_SYSTEM_ID     = 10'd6;
	localparam csr_reg_t REG_HARD_RESET    = 10'd7;

	// UART registers
	localparam csr_reg_t REG_UART_RXTX    = 10'd0;
	localparam csr_reg_t REG_UART_DIVISOR = 10'd1;

	// CPU interrupt lines, bits 2 and 3 unused
	localparam int IRQ_GPIO    = 0;
	localparam int IRQ_TIMER0  = 1;
	localparam int IRQ_UARTTX  = 4;

endpackage

// ==== csr_if.sv ====
// CSR bus interface with bridge and peripheral modports
`timescale 1ns/1ps

interface csr_if;
	import soc_ctl_pkg::*;

	// Word address, bank in the top bits
	csr_addr_t csr_a;
	// One-cycle write strobe
	logic      csr_we;
	// Write data from the bridge
	csr_data_t csr_dw;
	// Registered read data, zero when not addressed
	csr_data_t csr_dr;

	// Master side
	modport bridge (
		output csr_a,
		output csr_we,
		output csr_dw,
		input  csr_dr
	);

	// Bank side
	modport periph (
		input  csr_a,
		input  csr_we,
		input  csr_dw,
		output csr_dr
	);

endinterface

// ==== reset_gen.sv ====
// Reset request capture, system reset stretcher and flash reset release counter
`timescale 1ns/1ps

module reset_gen #(
	parameter int DEBOUNCE_CYCLES  = 64,
	// Must stay below DEBOUNCE_CYCLES
	parameter int FLASH_RST_CYCLES = 32,
	parameter int NINPUTS          = 3
) (
	input  logic               sys_clk,
	input  logic               trigger_reset,
	input  logic               hard_reset_i,
	input  logic [NINPUTS-1:0] btn_i,
	output logic               sys_rst_o,
	output logic               flash_rst_n_o
);

	localparam int RST_CNT_W   = $clog2(DEBOUNCE_CYCLES + 1);
	localparam int FLASH_CNT_W = $clog2(FLASH_RST_CYCLES + 1);
	localparam logic [RST_CNT_W-1:0]   RST_RELOAD = RST_CNT_W'(DEBOUNCE_CYCLES);
	localparam logic [FLASH_CNT_W-1:0] FLASH_LAST = FLASH_CNT_W'(FLASH_RST_CYCLES - 1);

	logic                   req_now;
	logic                   req_q;
	logic [RST_CNT_W-1:0]   rst_cnt;
	logic [FLASH_CNT_W-1:0] flash_cnt;
	logic                   sys_rst_q;
	logic                   flash_rst_n_q;

	// Pin, software or all buttons together
	assign req_now = trigger_reset | hard_reset_i | (&btn_i);

	always_ff @(posedge sys_clk) begin
		req_q <= req_now;
	end

	// ------------------------------
	// System reset stretch
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		if (req_q)
			rst_cnt <= RST_RELOAD;
		else if (rst_cnt != '0)
			rst_cnt <= rst_cnt - 1'b1;
	end

	// Raw request covers the gap before the counter reloads
	always_ff @(posedge sys_clk) begin
		sys_rst_q <= req_now | req_q | (rst_cnt != '0);
	end

	// ------------------------------
	// Boot flash released first
	// ------------------------------
	// Saturates one short of the count
	always_ff @(posedge sys_clk) begin
		if (req_q)
			flash_cnt <= '0;
		else if (flash_cnt != FLASH_LAST)
			flash_cnt <= flash_cnt + 1'b1;
	end

	always_ff @(posedge sys_clk) begin
		flash_rst_n_q <= ~req_now & ~req_q & (flash_cnt == FLASH_LAST);
	end

	assign sys_rst_o     = sys_rst_q;
	assign flash_rst_n_o = flash_rst_n_q;

endmodule

// ==== csr_bridge.sv ====
// Wishbone slave to CSR master sequencer with read-data combining
`timescale 1ns/1ps

module csr_bridge (
	input  logic                   sys_clk,
	input  logic                   sys_rst_i,
	input  soc_ctl_pkg::wb_adr_t   wb_adr_i,
	input  soc_ctl_pkg::csr_data_t wb_dat_i,
	output soc_ctl_pkg::csr_data_t wb_dat_o,
	input  logic                   wb_cyc_i,
	input  logic                   wb_stb_i,
	input  logic                   wb_we_i,
	output logic                   wb_ack_o,
	csr_if.bridge                  csr_uart,
	csr_if.bridge                  csr_sysctl
);
	import soc_ctl_pkg::*;

	typedef enum logic [1:0] {IDLE, ADDR, WAIT, ACK} brg_state_t;

	brg_state_t state;
	csr_addr_t  csr_a_q;
	logic       csr_we_q;
	csr_data_t  csr_dw_q;
	csr_data_t  csr_dr_all;

	// Banks decode themselves so one bus feeds both
	assign csr_uart.csr_a    = csr_a_q;
	assign csr_uart.csr_we   = csr_we_q;
	assign csr_uart.csr_dw   = csr_dw_q;
	assign csr_sysctl.csr_a  = csr_a_q;
	assign csr_sysctl.csr_we = csr_we_q;
	assign csr_sysctl.csr_dw = csr_dw_q;

	// Unselected banks return zero
	assign csr_dr_all = csr_uart.csr_dr | csr_sysctl.csr_dr;

	// ------------------------------
	// Access sequencer
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state    <= IDLE;
			csr_we_q <= 1'b0;
			wb_ack_o <= 1'b0;
		end else begin
			wb_ack_o <= 1'b0;
			csr_we_q <= 1'b0;
			case (state)
				// Skip the cycle where ack is still out
				IDLE: begin
					if (wb_cyc_i && wb_stb_i && !wb_ack_o)
						state <= ADDR;
				end
				// Address and write strobe go out
				ADDR: begin
					csr_we_q <= wb_we_i;
					state    <= WAIT;
				end
				// Banks register read data
				WAIT: begin
					state <= ACK;
				end
				ACK: begin
					wb_ack_o <= 1'b1;
					state    <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Address and data path
	always_ff @(posedge sys_clk) begin
		if (state == ADDR) begin
			// Word address from byte address
			csr_a_q  <= wb_adr_i[CSR_ADDR_W+1:2];
			csr_dw_q <= wb_dat_i;
		end
		if (state == ACK)
			wb_dat_o <= csr_dr_all;
	end

endmodule

// ==== sysctl.sv ====
// System controller CSR bank with GPIO, timer, system ID and hard reset
`timescale 1ns/1ps

module sysctl #(
	parameter soc_ctl_pkg::csr_bank_t csr_addr  = 4'h1,
	parameter int                     NINPUTS   = 3,
	parameter int                     NOUTPUTS  = 2,
	parameter soc_ctl_pkg::csr_data_t SYSTEM_ID = 32'h4D4F4E45
) (
	input  logic                sys_clk,
	input  logic                sys_rst_i,
	csr_if.periph               csr,
	input  logic [NINPUTS-1:0]  gpio_i,
	output logic [NOUTPUTS-1:0] gpio_o,
	output logic                gpio_irq_o,
	output logic                timer0_irq_o,
	output logic                hard_reset_o
);
	import soc_ctl_pkg::*;

	logic                sel;
	logic                wr;
	csr_reg_t            reg_idx;
	logic [NINPUTS-1:0]  gpio_s1;
	logic [NINPUTS-1:0]  gpio_s2;
	logic [NINPUTS-1:0]  gpio_prev;
	logic [NINPUTS-1:0]  irq_en;
	logic [NOUTPUTS-1:0] gpio_out;
	logic                timer_en;
	logic                timer_ar;
	csr_data_t           timer_cmp;
	csr_data_t           timer_cnt;
	logic                timer_hit;

	// Bank decode
	assign sel       = csr.csr_a[CSR_ADDR_W-1:CSR_REG_W] == csr_addr;
	assign reg_idx   = csr.csr_a[CSR_REG_W-1:0];
	assign wr        = sel & csr.csr_we;
	assign timer_hit = timer_en & (timer_cnt == timer_cmp);
	assign gpio_o    = gpio_out;

	// ------------------------------
	// Button synchronizer
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		gpio_s1   <= gpio_i;
		gpio_s2   <= gpio_s1;
		// Previous level for change detect
		gpio_prev <= gpio_s2;
	end

	// ------------------------------
	// Registers, timer and irqs
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			gpio_out     <= '0;
			irq_en       <= '0;
			timer_en     <= 1'b0;
			timer_ar     <= 1'b0;
			timer_cmp    <= '0;
			timer_cnt    <= '0;
			gpio_irq_o   <= 1'b0;
			timer0_irq_o <= 1'b0;
			hard_reset_o <= 1'b0;
		end else begin
			gpio_irq_o   <= |((gpio_s2 ^ gpio_prev) & irq_en);
			timer0_irq_o <= timer_hit;
			// Any write to the register asks for reset
			hard_reset_o <= wr & (reg_idx == REG_HARD_RESET);

			// Match wraps to zero, one-shot unless autorestart
			if (timer_hit) begin
				timer_cnt <= '0;
				timer_en  <= timer_ar;
			end else if (timer_en) begin
				timer_cnt <= timer_cnt + 1'b1;
			end

			// Bus writes win over the timer
			if (wr) begin
				case (reg_idx)
					REG_GPIO_OUT:      gpio_out  <= csr.csr_dw[NOUTPUTS-1:0];
					REG_GPIO_IRQ_EN:   irq_en    <= csr.csr_dw[NINPUTS-1:0];
					REG_TIMER_CTRL: begin
						timer_en <= csr.csr_dw[0];
						timer_ar <= csr.csr_dw[1];
					end
					REG_TIMER_COMPARE: timer_cmp <= csr.csr_dw;
					REG_TIMER_COUNTER: timer_cnt <= csr.csr_dw;
					default: begin
					end
				endcase
			end
		end
	end

	// ------------------------------
	// Read mux
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		if (!sel) begin
			csr.csr_dr <= '0;
		end else begin
			case (reg_idx)
				REG_GPIO_IN:       csr.csr_dr <= csr_data_t'(gpio_s2);
				REG_GPIO_OUT:      csr.csr_dr <= csr_data_t'(gpio_out);
				REG_GPIO_IRQ_EN:   csr.csr_dr <= csr_data_t'(irq_en);
				REG_TIMER_CTRL:    csr.csr_dr <= csr_data_t'({timer_ar, timer_en});
				REG_TIMER_COMPARE: csr.csr_dr <= timer_cmp;
				REG_TIMER_COUNTER: csr.csr_dr <= timer_cnt;
				REG_SYSTEM_ID:     csr.csr_dr <= SYSTEM_ID;
				// Hard reset and holes read zero
				default:           csr.csr_dr <= '0;
			endcase
		end
	end

endmodule

// ==== uart_tx.sv ====
// UART transmitter CSR bank with divisor register and done interrupt
`timescale 1ns/1ps

module uart_tx #(
	parameter soc_ctl_pkg::csr_bank_t csr_addr = 4'h0,
	parameter int                     CLK_FREQ = 50000000,
	parameter int                     BAUD     = 3125000
) (
	input  logic  sys_clk,
	input  logic  sys_rst_i,
	csr_if.periph csr,
	output logic  tx_irq_o,
	output logic  uart_tx_o
);
	import soc_ctl_pkg::*;

	typedef enum logic [1:0] {IDLE, START, DATA, STOP} tx_state_t;

	// Cycles per bit after reset
	localparam logic [15:0] DIV_DEFAULT = 16'(CLK_FREQ / BAUD);

	tx_state_t   state;
	logic        sel;
	logic        wr;
	csr_reg_t    reg_idx;
	logic        busy;
	logic        bit_end;
	logic [15:0] divisor;
	logic [15:0] bit_cnt;
	logic [2:0]  bit_idx;
	logic [7:0]  shift;
	logic        tx_q;

	assign sel       = csr.csr_a[CSR_ADDR_W-1:CSR_REG_W] == csr_addr;
	assign reg_idx   = csr.csr_a[CSR_REG_W-1:0];
	assign wr        = sel & csr.csr_we;
	assign busy      = state != IDLE;
	assign bit_end   = bit_cnt == divisor - 1'b1;
	assign uart_tx_o = tx_q;

	// ------------------------------
	// Transmit FSM
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state    <= IDLE;
			divisor  <= DIV_DEFAULT;
			bit_cnt  <= '0;
			bit_idx  <= '0;
			tx_q     <= 1'b1;
			tx_irq_o <= 1'b0;
		end else begin
			tx_irq_o <= 1'b0;
			if (wr && reg_idx == REG_UART_DIVISOR)
				divisor <= csr.csr_dw[15:0];
			// Bit period counter
			if (busy)
				bit_cnt <= bit_end ? '0 : bit_cnt + 1'b1;
			case (state)
				// Writes while busy fall through here unseen
				IDLE: begin
					if (wr && reg_idx == REG_UART_RXTX) begin
						shift   <= csr.csr_dw[7:0];
						bit_cnt <= '0;
						tx_q    <= 1'b0;
						state   <= START;
					end
				end
				START: begin
					if (bit_end) begin
						bit_idx <= '0;
						tx_q    <= shift[0];
						state   <= DATA;
					end
				end
				// LSB first
				DATA: begin
					if (bit_end) begin
						if (bit_idx == 3'd7) begin
							tx_q  <= 1'b1;
							state <= STOP;
						end else begin
							bit_idx <= bit_idx + 1'b1;
							tx_q    <= shift[1];
							shift   <= shift >> 1;
						end
					end
				end
				STOP: begin
					if (bit_end) begin
						tx_irq_o <= 1'b1;
						state    <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Busy flag or divisor readback
	always_ff @(posedge sys_clk) begin
		if (!sel)
			csr.csr_dr <= '0;
		else if (reg_idx == REG_UART_RXTX)
			csr.csr_dr <= csr_data_t'(busy);
		else if (reg_idx == REG_UART_DIVISOR)
			csr.csr_dr <= csr_data_t'(divisor);
		else
			csr.csr_dr <= '0;
	end

endmodule

// ==== soc_ctl.sv ====
// System control top level with reset, CSR bridge, banks and interrupt vector
`timescale 1ns/1ps

module soc_ctl #(
	parameter int                     DEBOUNCE_CYCLES  = 64,
	parameter int                     FLASH_RST_CYCLES = 32,
	parameter int                     CLK_FREQ         = 50000000,
	parameter int                     BAUD             = 3125000,
	parameter soc_ctl_pkg::csr_data_t SYSTEM_ID        = 32'h4D4F4E45,
	parameter int                     NINPUTS          = 3,
	parameter int                     NOUTPUTS         = 2
) (
	input  logic                   sys_clk,
	input  logic                   trigger_reset,
	input  soc_ctl_pkg::wb_adr_t   wb_adr_i,
	input  soc_ctl_pkg::csr_data_t wb_dat_i,
	output soc_ctl_pkg::csr_data_t wb_dat_o,
	input  logic                   wb_cyc_i,
	input  logic                   wb_stb_i,
	input  logic                   wb_we_i,
	output logic                   wb_ack_o,
	input  logic [NINPUTS-1:0]     btn_i,
	output logic [NOUTPUTS-1:0]    led_o,
	output logic                   uart_tx_o,
	output logic                   flash_rst_n_o,
	output logic                   periph_rst_n_o,
	output soc_ctl_pkg::irq_vec_t  cpu_irq_o
);
	import soc_ctl_pkg::*;

	logic sys_rst;
	logic hard_reset;
	logic gpio_irq;
	logic timer0_irq;
	logic uarttx_irq;

	// One CSR bus copy per bank
	csr_if csr_uart ();
	csr_if csr_sysctl ();

	// ------------------------------
	// Reset and bus
	// ------------------------------
	reset_gen #(
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
		.FLASH_RST_CYCLES(FLASH_RST_CYCLES),
		.NINPUTS         (NINPUTS)
	) reset_gen_i (
		.sys_clk      (sys_clk),
		.trigger_reset(trigger_reset),
		.hard_reset_i (hard_reset),
		.btn_i        (btn_i),
		.sys_rst_o    (sys_rst),
		.flash_rst_n_o(flash_rst_n_o)
	);

	assign periph_rst_n_o = ~sys_rst;

	csr_bridge csr_bridge_i (
		.sys_clk   (sys_clk),
		.sys_rst_i (sys_rst),
		.wb_adr_i  (wb_adr_i),
		.wb_dat_i  (wb_dat_i),
		.wb_dat_o  (wb_dat_o),
		.wb_cyc_i  (wb_cyc_i),
		.wb_stb_i  (wb_stb_i),
		.wb_we_i   (wb_we_i),
		.wb_ack_o  (wb_ack_o),
		.csr_uart  (csr_uart),
		.csr_sysctl(csr_sysctl)
	);

	// ------------------------------
	// CSR banks
	// ------------------------------
	sysctl #(
		.csr_addr (CSR_BANK_SYSCTL),
		.NINPUTS  (NINPUTS),
		.NOUTPUTS (NOUTPUTS),
		.SYSTEM_ID(SYSTEM_ID)
	) sysctl_i (
		.sys_clk     (sys_clk),
		.sys_rst_i   (sys_rst),
		.csr         (csr_sysctl),
		.gpio_i      (btn_i),
		.gpio_o      (led_o),
		.gpio_irq_o  (gpio_irq),
		.timer0_irq_o(timer0_irq),
		.hard_reset_o(hard_reset)
	);

	uart_tx #(
		.csr_addr(CSR_BANK_UART),
		.CLK_FREQ(CLK_FREQ),
		.BAUD    (BAUD)
	) uart_tx_i (
		.sys_clk  (sys_clk),
		.sys_rst_i(sys_rst),
		.csr      (csr_uart),
		.tx_irq_o (uarttx_irq),
		.uart_tx_o(uart_tx_o)
	);

	// Legacy bit positions kept, dropped sources stay zero
	always_comb begin
		cpu_irq_o             = '0;
		cpu_irq_o[IRQ_GPIO]   = gpio_irq;
		cpu_irq_o[IRQ_TIMER0] = timer0_irq;
		cpu_irq_o[IRQ_UARTTX] = uarttx_irq;
	end

endmodule

// ==== tb_soc_ctl.sv ====
// Testbench for soc_ctl with transaction table, serial decoder, interrupt monitor and watchdog
`timescale 1ns/1ps

module tb_soc_ctl;
	import soc_ctl_pkg::*;

	localparam int        DEBOUNCE  = 64;
	localparam int        FLASH_RST = 32;
	localparam int        DIV_DEF   = 16;
	localparam csr_data_t SYS_ID    = 32'h4D4F4E45;
	localparam int        N_TR      = 10;
	localparam int        ACK_LIMIT = 16;
	// Longest frame, divisor up to 16
	localparam int        FRAME_MAX = 10 * 16;
	localparam int        TMR_MAX   = 60;
	// Table, three reset runs, four frames, timer runs and the other accesses
	localparam int        WD_CYCLES = 2 * (N_TR * 8 + 3 * (DEBOUNCE + 16) + 4 * FRAME_MAX
		+ 6 * (TMR_MAX + 2) + 40 * 8);
	// Interrupt lines that still have a source
	localparam irq_vec_t  IRQ_USED  = (irq_vec_t'(1) << IRQ_GPIO)
		| (irq_vec_t'(1) << IRQ_TIMER0) | (irq_vec_t'(1) << IRQ_UARTTX);

	logic      sys_clk;
	logic      trigger_reset;
	wb_adr_t   wb_adr_i;
	csr_data_t wb_dat_i;
	csr_data_t wb_dat_o;
	logic      wb_cyc_i;
	logic      wb_stb_i;
	logic      wb_we_i;
	logic      wb_ack_o;
	logic [2:0] btn_i;
	logic [1:0] led_o;
	logic      uart_tx_o;
	logic      flash_rst_n_o;
	logic      periph_rst_n_o;
	irq_vec_t  cpu_irq_o;

	int err_cnt;
	int chk_cnt;
	int irq_cnt [32];
	int frames_rx;
	logic dec_en;
	int dec_div;
	logic [7:0] exp_bytes [$];

	// Transaction table
	logic      tr_we   [N_TR];
	wb_adr_t   tr_adr  [N_TR];
	csr_data_t tr_wdat [N_TR];
	csr_data_t tr_exp  [N_TR];
	csr_data_t tr_mask [N_TR];

	soc_ctl soc_ctl_i (
		.sys_clk       (sys_clk),
		.trigger_reset (trigger_reset),
		.wb_adr_i      (wb_adr_i),
		.wb_dat_i      (wb_dat_i),
		.wb_dat_o      (wb_dat_o),
		.wb_cyc_i      (wb_cyc_i),
		.wb_stb_i      (wb_stb_i),
		.wb_we_i       (wb_we_i),
		.wb_ack_o      (wb_ack_o),
		.btn_i         (btn_i),
		.led_o         (led_o),
		.uart_tx_o     (uart_tx_o),
		.flash_rst_n_o (flash_rst_n_o),
		.periph_rst_n_o(periph_rst_n_o),
		.cpu_irq_o     (cpu_irq_o)
	);

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	// ------------------------------
	// Check helpers
	// ------------------------------
	task automatic check_val(input string name, input csr_data_t got, input csr_data_t exp);
		chk_cnt++;
		assert (got === exp) else begin
			err_cnt++;
			$display("FAIL %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic expect_true(input logic cond, input string msg);
		chk_cnt++;
		assert (cond) else begin
			err_cnt++;
			$display("Error: %s", msg);
		end
	endtask

	// Byte address of a bank register
	function automatic wb_adr_t reg_addr(input csr_bank_t bank, input csr_reg_t idx);
		return {16'h0, bank, idx, 2'b00};
	endfunction

	task automatic clear_irq_counts();
		for (int i = 0; i < 32; i++)
			irq_cnt[i] = 0;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge sys_clk);
	endtask

	// ------------------------------
	// Wishbone master
	// ------------------------------
	task automatic bus_access(input logic we, input wb_adr_t adr, input csr_data_t wdat,
		output csr_data_t rdat);
		int waited;
		waited = 0;
		@(posedge sys_clk);
		wb_cyc_i <= 1'b1;
		wb_stb_i <= 1'b1;
		wb_we_i  <= we;
		wb_adr_i <= adr;
		wb_dat_i <= wdat;
		do begin
			@(posedge sys_clk);
			#1;
			waited++;
		end while (wb_ack_o !== 1'b1 && waited < ACK_LIMIT);
		expect_true(wb_ack_o === 1'b1,
			$sformatf("no acknowledge for access at address %h", adr));
		rdat = wb_dat_o;
		@(posedge sys_clk);
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
		wb_we_i  <= 1'b0;
		#1;
		// Ack is a single-cycle pulse
		check_val("wb_ack_o", csr_data_t'(wb_ack_o), 32'h0);
	endtask

	task automatic bus_write(input wb_adr_t adr, input csr_data_t wdat);
		csr_data_t dummy;
		bus_access(1'b1, adr, wdat, dummy);
	endtask

	task automatic bus_read(input wb_adr_t adr, output csr_data_t rdat);
		bus_access(1'b0, adr, 32'h0, rdat);
	endtask

	// Counts edges until each reset output rises
	task automatic measure_release(input int first_edge);
		int flash_at;
		int per_at;
		flash_at = -1;
		per_at   = -1;
		for (int k = first_edge; k <= DEBOUNCE + 8; k++) begin
			@(posedge sys_clk);
			#1;
			if (flash_at < 0 && flash_rst_n_o === 1'b1)
				flash_at = k;
			if (per_at < 0 && periph_rst_n_o === 1'b1)
				per_at = k;
		end
		check_val("flash_rst_n_o release edge", csr_data_t'(flash_at), FLASH_RST);
		check_val("periph_rst_n_o release edge", csr_data_t'(per_at), DEBOUNCE + 1);
	endtask

	// ------------------------------
	// Interrupt monitor
	// ------------------------------
	always @(posedge sys_clk) begin
		for (int i = 0; i < 32; i++)
			if (cpu_irq_o[i] === 1'b1)
				irq_cnt[i]++;
		// Lines of the dropped sources stay low
		check_val("cpu_irq_o unused bits", cpu_irq_o & ~IRQ_USED, 32'h0);
	end

	// ------------------------------
	// Serial decoder
	// ------------------------------
	initial begin
		logic [7:0] rx;
		logic [7:0] want;
		forever begin
			@(negedge uart_tx_o);
			if (dec_en) begin
				wait_cycles(dec_div / 2);
				#1;
				expect_true(uart_tx_o === 1'b0, "start bit not held low at its middle");
				for (int b = 0; b < 8; b++) begin
					wait_cycles(dec_div);
					#1;
					rx[b] = uart_tx_o;
				end
				wait_cycles(dec_div);
				#1;
				check_val("uart_tx_o stop bit", csr_data_t'(uart_tx_o), 32'h1);
				expect_true(exp_bytes.size() != 0, "serial frame received with no byte pending");
				if (exp_bytes.size() != 0) begin
					want = exp_bytes.pop_front();
					check_val("uart_tx_o byte", csr_data_t'(rx), csr_data_t'(want));
				end
				frames_rx++;
			end
		end
	end

	// Watchdog
	initial begin
		wait_cycles(WD_CYCLES);
		$display("Error: watchdog expired, the tests did not complete in time");
		$display("Simulation finished: FAIL");
		$finish;
	end

	task automatic build_table();
		csr_data_t led_a;
		csr_data_t led_b;
		led_a = $urandom;
		led_b = $urandom;
		for (int i = 0; i < N_TR; i++) begin
			tr_we[i]   = 1'b0;
			tr_wdat[i] = 32'h0;
			tr_exp[i]  = 32'h0;
			tr_mask[i] = 32'hFFFF_FFFF;
		end
		tr_adr[0] = reg_addr(CSR_BANK_SYSCTL, REG_SYSTEM_ID);
		tr_exp[0] = SYS_ID;
		tr_we[1]   = 1'b1;
		tr_adr[1]  = reg_addr(CSR_BANK_SYSCTL, REG_GPIO_OUT);
		tr_wdat[1] = led_a;
		tr_adr[2]  = reg_addr(CSR_BANK_SYSCTL, REG_GPIO_OUT);
		tr_exp[2]  = led_a & 32'h3;
		tr_we[3]   = 1'b1;
		tr_adr[3]  = reg_addr(CSR_BANK_SYSCTL, REG_GPIO_OUT);
		tr_wdat[3] = led_b;
		tr_adr[4]  = reg_addr(CSR_BANK_SYSCTL, REG_GPIO_OUT);
		tr_exp[4]  = led_b & 32'h3;
		// Hard reset and unused locations read zero
		tr_adr[5]  = reg_addr(CSR_BANK_SYSCTL, REG_HARD_RESET);
		tr_adr[6]  = reg_addr(CSR_BANK_SYSCTL, 10'd9);
		tr_adr[7]  = reg_addr(4'd2, 10'd0);
		tr_adr[8]  = reg_addr(CSR_BANK_UART, 10'd5);
		tr_adr[9]  = reg_addr(CSR_BANK_UART, REG_UART_DIVISOR);
		tr_exp[9]  = DIV_DEF;
		tr_mask[9] = 32'h0000_FFFF;
	endtask

	// ------------------------------
	// Test sequence
	// ------------------------------
	initial begin
		csr_data_t rd;
		int cmp;
		int waited;
		logic [7:0] b;
		trigger_reset = 1'b1;
		wb_adr_i      = '0;
		wb_dat_i      = '0;
		wb_cyc_i      = 1'b0;
		wb_stb_i      = 1'b0;
		wb_we_i       = 1'b0;
		btn_i         = 3'b000;
		err_cnt       = 0;
		chk_cnt       = 0;
		frames_rx     = 0;
		dec_en        = 1'b0;
		dec_div       = DIV_DEF;
		clear_irq_counts();
		void'($urandom(32'h683a_3971));
		build_table();

		// Power-on reset release
		wait_cycles(3);
		trigger_reset <= 1'b0;
		measure_release(0);

		// Register access table
		for (int i = 0; i < N_TR; i++) begin
			bus_access(tr_we[i], tr_adr[i], tr_wdat[i], rd);
			if (tr_we[i] && tr_adr[i] == reg_addr(CSR_BANK_SYSCTL, REG_GPIO_OUT))
				check_val("led_o", csr_data_t'(led_o), tr_wdat[i] & 32'h3);
			if (!tr_we[i])
				check_val("wb_dat_o", rd & tr_mask[i], tr_exp[i] & tr_mask[i]);
		end

		// GPIO change interrupt, button 1 only
		bus_write(reg_addr(CSR_BANK_SYSCTL, REG_GPIO_IRQ_EN), 32'h2);
		clear_irq_counts();
		@(posedge sys_clk);
		btn_i <= 3'b010;
		wait_cycles(6);
		bus_read(reg_addr(CSR_BANK_SYSCTL, REG_GPIO_IN), rd);
		check_val("gpio_in", rd, 32'h2);
		check_val("cpu_irq_o[0] pulses", irq_cnt[IRQ_GPIO], 32'h1);
		@(posedge sys_clk);
		btn_i <= 3'b110;
		wait_cycles(6);
		bus_read(reg_addr(CSR_BANK_SYSCTL, REG_GPIO_IN), rd);
		check_val("gpio_in", rd, 32'h6);
		check_val("cpu_irq_o[0] pulses", irq_cnt[IRQ_GPIO], 32'h1);
		@(posedge sys_clk);
		btn_i <= 3'b000;
		wait_cycles(6);

		// One-shot timer
		cmp = 20 + int'($urandom % 41);
		bus_write(reg_addr(CSR_BANK_SYSCTL, REG_TIMER_COMPARE), cmp);
		bus_write(reg_addr(CSR_BANK_SYSCTL, REG_TIMER_COUNTER), 32'h0);
		clear_irq_counts();
		bus_write(reg_addr(CSR_BANK_SYSCTL, REG_TIMER_CTRL), 32'h1);
		waited = 0;
		while (irq_cnt[IRQ_TIMER0] == 0 && waited < 2 * (TMR_MAX + 8)) begin
			@(posedge sys_clk);
			waited++;
		end
		wait_cycles(2 * cmp);
		check_val("cpu_irq_o[1] pulses", irq_cnt[IRQ_TIMER0], 32'h1);
		bus_read(reg_addr(CSR_BANK_SYSCTL, REG_TIMER_CTRL), rd);
		check_val("timer_ctrl", rd, 32'h0);

		// Autorestart keeps firing
		clear_irq_counts();
		bus_write(reg_addr(CSR_BANK_SYSCTL, REG_TIMER_CTRL), 32'h3);
		waited = 0;
		while (irq_cnt[IRQ_TIMER0] < 3 && waited < 4 * (TMR_MAX + 2)) begin
			@(posedge sys_clk);
			waited++;
		end
		expect_true(irq_cnt[IRQ_TIMER0] >= 3,
			"timer with autorestart stopped giving interrupts");
		bus_write(reg_addr(CSR_BANK_SYSCTL, REG_TIMER_CTRL), 32'h0);

		// UART frames
		dec_div = 8 + int'($urandom % 9);
		bus_write(reg_addr(CSR_BANK_UART, REG_UART_DIVISOR), dec_div);
		dec_en = 1'b1;
		clear_irq_counts();
		for (int i = 0; i < 3; i++) begin
			waited = 0;
			do begin
				bus_read(reg_addr(CSR_BANK_UART, REG_UART_RXTX), rd);
				waited++;
			end while (rd[0] && waited < FRAME_MAX);
			expect_true(!rd[0], "UART stayed busy");
			b = $urandom;
			exp_bytes.push_back(b);
			bus_write(reg_addr(CSR_BANK_UART, REG_UART_RXTX), b);
			// Sent while busy, must be dropped
			if (i == 0)
				bus_write(reg_addr(CSR_BANK_UART, REG_UART_RXTX), 32'hA5);
		end
		waited = 0;
		while (frames_rx < 3 && waited < 4 * FRAME_MAX) begin
			@(posedge sys_clk);
			waited++;
		end
		wait_cycles(12 * dec_div);
		check_val("uart frames", frames_rx, 32'h3);
		check_val("cpu_irq_o[4] pulses", irq_cnt[IRQ_UARTTX], 32'h3);
		dec_en = 1'b0;

		// Software hard reset
		bus_write(reg_addr(CSR_BANK_SYSCTL, REG_HARD_RESET), 32'h1);
		check_val("flash_rst_n_o", csr_data_t'(flash_rst_n_o), 32'h0);
		check_val("periph_rst_n_o", csr_data_t'(periph_rst_n_o), 32'h0);
		measure_release(1);

		// All three buttons held
		@(posedge sys_clk);
		btn_i <= 3'b111;
		wait_cycles(5);
		#1;
		check_val("periph_rst_n_o", csr_data_t'(periph_rst_n_o), 32'h0);
		@(posedge sys_clk);
		btn_i <= 3'b000;
		measure_release(0);

		$display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== soc_ctl.f ====
soc_ctl_pkg.sv
csr_if.sv
reset_gen.sv
csr_bridge.sv
sysctl.sv
uart_tx.sv
soc_ctl.sv
tb_soc_ctl.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build with Verilator, run, and judge the result from the simulation log

verilator --binary --timing -Wno-fatal --top-module tb_soc_ctl -f soc_ctl.f \
	-o vsim_soc_ctl > build.log 2>&1 \
	&& ./obj_dir/vsim_soc_ctl > sim.log 2>&1 \
	|| { echo "Build or run failed, see build.log and sim.log"; exit 1; }

cat sim.log

grep -q "Simulation finished: FAIL" sim.log \
	&& { echo "Test failed"; exit 1; } \
	|| { grep -q "Simulation finished: PASS" sim.log \
	|| { echo "No result found in sim.log"; exit 1; }; }

exit 0
